// File: filelist.f
+incdir+sim
hw/permu_cfg_pkg.sv
hw/permu_insn_pkg.sv
hw/permu_insn_queue.sv
hw/permu_network.sv
hw/permu_result_writer.sv
hw/permu_top.sv
sim/tb_permu.sv

// File: Bender.yml
package:
  name: permu

sources:
  - hw/permu_cfg_pkg.sv
  - hw/permu_insn_pkg.sv
  - hw/permu_insn_queue.sv
  - hw/permu_network.sv
  - hw/permu_result_writer.sv
  - hw/permu_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_permu.sv

// File: sim/tb_permu_model.svh
// Reference model of the 16-bit lane interleaving and of both gather modes
`ifndef TB_PERMU_MODEL_SVH
`define TB_PERMU_MODEL_SVH

// Element e of an operand, found in lane e mod 4 at slot e div 4
function automatic logic [15:0] lane_elem16(input lane_data_t data, input int e);
   return data[e % NumLanes][16*(e / NumLanes) +: 16];
endfunction

// Expected lane words of one permutation
function automatic lane_data_t expected_permute(input lane_data_t val,
                                                input lane_data_t idx,
                                                input logic       byte_mode);
   logic [255:0] val_lin;
   logic [255:0] idx_lin;
   logic [255:0] res_lin;
   lane_data_t   res;
   int           src;
   for (int e = 0; e < NumElems16; e++) begin
      val_lin[16*e +: 16] = lane_elem16(val, e);
      idx_lin[16*e +: 16] = lane_elem16(idx, e);
   end
   if (byte_mode) begin
      // Low byte of each element comes first
      for (int k = 0; k < 32; k++) begin
         src = idx_lin[8*k +: 8] % 32;
         res_lin[8*k +: 8] = val_lin[8*src +: 8];
      end
   end else begin
      for (int k = 0; k < NumElems16; k++) begin
         src = idx_lin[16*k +: 16] % NumElems16;
         res_lin[16*k +: 16] = val_lin[16*src +: 16];
      end
   end
   // Back onto the lanes by the same rule
   for (int e = 0; e < NumElems16; e++) begin
      res[e % NumLanes][16*(e / NumLanes) +: 16] = res_lin[16*e +: 16];
   end
   return res;
endfunction

`endif

// File: sim/tb_permu.sv
// Testbench for the permutation unit with random stimulus, grant generator and scoreboard
`timescale 1ns/1ns
`default_nettype none

module tb_permu import permu_cfg_pkg::*, permu_insn_pkg::*; ();

   localparam int NumInsn       = 40;
   localparam int TimeoutCycles = NumInsn * 64;
   localparam int Seed          = 90491;
   localparam int BlockAt       = 12;

   logic                  clk;
   logic                  rst_n;
   logic                  pe_req_valid;
   vid_t                  pe_req_id;
   vreg_t                 pe_req_vd;
   permu_mode_e           pe_req_mode;
   vfu_e                  pe_req_vfu;
   logic                  pe_req_ready;
   logic [NrVInsn-1:0]    pe_resp_done;
   logic                  operand_valid;
   logic                  sel_idx_val;
   lane_data_t            operand;
   logic                  operand_ready;
   logic [NumLanes-1:0]   result_req;
   vaddr_t [NumLanes-1:0] result_addr;
   lane_data_t            result_wdata;
   logic [NumLanes-1:0]   result_gnt;

   // Accepted permutations, then their expected writes
   vid_t        ins_id_q[$];
   vreg_t       ins_vd_q[$];
   permu_mode_e ins_mode_q[$];
   vid_t        wr_id_q[$];
   vreg_t       wr_vd_q[$];
   lane_data_t  wr_data_q[$];

   logic checking;
   logic block_gnt;
   logic full_seen;
   logic done_pending;
   vid_t done_id;
   int   outstanding;
   int   committed;
   int   cycles;

   `include "tb_permu_model.svh"

   permu_top DUT (
      .clk_i                (clk),
      .rst_ni               (rst_n),
      .pe_req_valid_i       (pe_req_valid),
      .pe_req_id_i          (pe_req_id),
      .pe_req_vd_i          (pe_req_vd),
      .pe_req_mode_i        (pe_req_mode),
      .pe_req_vfu_i         (pe_req_vfu),
      .pe_req_ready_o       (pe_req_ready),
      .pe_resp_done_o       (pe_resp_done),
      .operand_valid_i      (operand_valid),
      .sel_idx_val_i        (sel_idx_val),
      .operand_i            (operand),
      .operand_ready_o      (operand_ready),
      .permu_result_req_o   (result_req),
      .permu_result_addr_o  (result_addr),
      .permu_result_wdata_o (result_wdata),
      .permu_result_gnt_i   (result_gnt)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Random source and helpers
   ////////////////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(inout logic [31:0] state, input int n, output logic [63:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         state   = lfsr_step(state);
         bits[i] = state[0];
      end
   endtask

   task automatic draw_lanes(inout logic [31:0] state, output lane_data_t data);
      logic [63:0] r;
      for (int l = 0; l < NumLanes; l++) begin
         draw_bits(state, ElemWidth, r);
         data[l] = r;
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Holds one operand beat until the network takes it
   task automatic send_beat(input logic sel, input lane_data_t data);
      operand_valid = 1'b1;
      sel_idx_val   = sel;
      operand       = data;
      @(posedge clk);
      while (!operand_ready) @(posedge clk);
      #1;
      operand_valid = 1'b0;
   endtask

   task automatic stop_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [255:0] got,
                                  input logic [255:0] exp);
      $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      stop_run();
   endtask

   ////////////////////////////////////////////////////////////
   // Scoreboard, sampled at the rising edge
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin : monitor
      logic [NrVInsn-1:0] exp_done;
      vaddr_t             exp_addr;
      if (checking) begin
         cycles = cycles + 1;
         if (cycles > TimeoutCycles) begin
            $display("Timeout after %0d cycles, %0d results committed", cycles, committed);
            stop_run();
         end
         exp_done = done_pending ? (NrVInsn'(1) << done_id) : '0;
         assert (pe_resp_done == exp_done)
            else report_mismatch("pe_resp_done_o", pe_resp_done, exp_done);
         done_pending = 1'b0;
         assert (pe_req_ready == (outstanding != InsnQueueDepth))
            else report_mismatch("pe_req_ready_o", pe_req_ready, outstanding != InsnQueueDepth);
         if (outstanding == InsnQueueDepth) full_seen = 1'b1;
         if (pe_req_valid && pe_req_ready && pe_req_vfu == VFU_PERMU) outstanding++;
         if (result_req != '0) begin
            assert (wr_id_q.size() != 0) else begin
               $display("Write request at %0t with no permutation pending", $time);
               stop_run();
            end
            assert (result_req == '1)
               else report_mismatch("permu_result_req_o", result_req, 4'hf);
            // Eight words per register in each lane
            exp_addr = {wr_vd_q[0], 3'b000};
            for (int l = 0; l < NumLanes; l++) begin
               assert (result_addr[l] == exp_addr)
                  else report_mismatch("permu_result_addr_o", result_addr[l], exp_addr);
            end
            assert (result_wdata == wr_data_q[0])
               else report_mismatch("permu_result_wdata_o", result_wdata, wr_data_q[0]);
            // Oldest write retires on a full grant
            if (result_gnt == '1) begin
               done_pending = 1'b1;
               done_id      = wr_id_q.pop_front();
               void'(wr_vd_q.pop_front());
               void'(wr_data_q.pop_front());
               outstanding--;
               committed++;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin : requests
      logic [31:0] lfsr;
      logic [63:0] r;
      int          sent;
      vid_t        next_id;
      lfsr    = Seed;
      sent    = 0;
      next_id = '0;
      wait (checking);
      while (sent < NumInsn) begin
         draw_bits(lfsr, 14, r);
         // Grants held back once so the queue fills
         if (sent == BlockAt && !full_seen) block_gnt = 1'b1;
         pe_req_valid = 1'b1;
         pe_req_vd    = r[4:0];
         pe_req_mode  = r[5] ? PERMU_GATHER8 : PERMU_GATHER16;
         if (r[7:6] == 2'd0) begin
            pe_req_vfu = r[8] ? VFU_LOAD : VFU_ALU;
            pe_req_id  = r[11:9];
         end else begin
            pe_req_vfu = VFU_PERMU;
            pe_req_id  = next_id;
         end
         @(posedge clk);
         while (!pe_req_ready) @(posedge clk);
         if (pe_req_vfu == VFU_PERMU) begin
            ins_id_q.push_back(pe_req_id);
            ins_vd_q.push_back(pe_req_vd);
            ins_mode_q.push_back(pe_req_mode);
            sent++;
            next_id = next_id + 1'b1;
         end
         #1;
         pe_req_valid = 1'b0;
         idle_cycles(r[13:12]);
      end
   end

   initial begin : operands
      logic [31:0] lfsr;
      logic [63:0] r;
      lane_data_t  val;
      lane_data_t  idx;
      lfsr = Seed;
      // Own stretch of the sequence
      repeat (64) draw_bits(lfsr, 64, r);
      wait (checking);
      for (int n = 0; n < NumInsn; n++) begin
         while (ins_id_q.size() == 0) idle_cycles(1);
         draw_lanes(lfsr, val);
         draw_lanes(lfsr, idx);
         draw_bits(lfsr, 5, r);
         idle_cycles(r[1:0]);
         if (r[2]) begin
            send_beat(1'b1, idx);
            idle_cycles(r[4:3]);
            send_beat(1'b0, val);
         end else begin
            send_beat(1'b0, val);
            idle_cycles(r[4:3]);
            send_beat(1'b1, idx);
         end
         wr_id_q.push_back(ins_id_q.pop_front());
         wr_vd_q.push_back(ins_vd_q.pop_front());
         wr_data_q.push_back(expected_permute(val, idx, ins_mode_q.pop_front() == PERMU_GATHER8));
      end
   end

   initial begin : grants
      logic [31:0] lfsr;
      logic [63:0] r;
      lfsr = Seed;
      repeat (1024) draw_bits(lfsr, 64, r);
      wait (checking);
      forever begin
         draw_bits(lfsr, 6, r);
         if (block_gnt && full_seen) block_gnt = 1'b0;
         // Lane 0 withheld while blocking
         if (block_gnt) result_gnt = r[5:2] & 4'b1110;
         else if (r[1:0] == 2'd0) result_gnt = '1;
         else result_gnt = r[5:2];
         idle_cycles(1);
      end
   end

   initial begin
      rst_n         = 1'b0;
      pe_req_valid  = 1'b0;
      pe_req_id     = '0;
      pe_req_vd     = '0;
      pe_req_mode   = PERMU_GATHER16;
      pe_req_vfu    = VFU_ALU;
      operand_valid = 1'b0;
      sel_idx_val   = 1'b0;
      operand       = '0;
      result_gnt    = '0;
      checking      = 1'b0;
      block_gnt     = 1'b0;
      full_seen     = 1'b0;
      done_pending  = 1'b0;
      done_id       = '0;
      outstanding   = 0;
      committed     = 0;
      cycles        = 0;
      repeat (8) @(posedge clk);
      assert (result_req == '0) else report_mismatch("permu_result_req_o", result_req, 0);
      assert (!operand_ready) else report_mismatch("operand_ready_o", operand_ready, 0);
      assert (pe_resp_done == '0) else report_mismatch("pe_resp_done_o", pe_resp_done, 0);
      assert (!pe_req_ready) else report_mismatch("pe_req_ready_o", pe_req_ready, 0);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      checking = 1'b1;
      wait (committed == NumInsn);
      repeat (8) @(posedge clk);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/permu_top.sv
// Permutation unit top level with instruction queue, network and result writer
`timescale 1ns/1ns
`default_nettype none

module permu_top import permu_cfg_pkg::*; import permu_insn_pkg::*; (
   input  wire logic                clk_i,
   input  wire logic                rst_ni,
   // Sequencer
   input  wire logic                pe_req_valid_i,
   input  wire vid_t                pe_req_id_i,
   input  wire vreg_t               pe_req_vd_i,
   input  wire permu_mode_e         pe_req_mode_i,
   input  wire vfu_e                pe_req_vfu_i,
   output logic                     pe_req_ready_o,
   output logic [NrVInsn-1:0]       pe_resp_done_o,
   // Operands from the lanes
   input  wire logic                operand_valid_i,
   input  wire logic                sel_idx_val_i,
   input  wire lane_data_t          operand_i,
   output logic                     operand_ready_o,
   // Result write to the lanes
   output logic [NumLanes-1:0]      permu_result_req_o,
   output vaddr_t [NumLanes-1:0]    permu_result_addr_o,
   output lane_data_t               permu_result_wdata_o,
   input  wire logic [NumLanes-1:0] permu_result_gnt_i
);

   logic        issue_valid;
   permu_mode_e issue_mode;
   vreg_t       issue_vd;
   logic        net_valid;
   lane_data_t  net_data;
   logic        writer_ready;
   logic        handoff;
   logic        commit;

   // Network result moves into the writer
   assign handoff = net_valid && writer_ready;

   permu_insn_queue i_insn_queue (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .pe_req_valid_i (pe_req_valid_i),
      .pe_req_id_i    (pe_req_id_i),
      .pe_req_vd_i    (pe_req_vd_i),
      .pe_req_mode_i  (pe_req_mode_i),
      .pe_req_vfu_i   (pe_req_vfu_i),
      .issue_done_i   (handoff),
      .commit_i       (commit),
      .pe_req_ready_o (pe_req_ready_o),
      .issue_valid_o  (issue_valid),
      .issue_mode_o   (issue_mode),
      .issue_vd_o     (issue_vd),
      .pe_resp_done_o (pe_resp_done_o)
   );

   permu_network i_network (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .issue_valid_i   (issue_valid),
      .issue_mode_i    (issue_mode),
      .operand_valid_i (operand_valid_i),
      .sel_idx_val_i   (sel_idx_val_i),
      .operand_i       (operand_i),
      .out_ready_i     (handoff),
      .operand_ready_o (operand_ready_o),
      .out_valid_o     (net_valid),
      .out_data_o      (net_data)
   );

   permu_result_writer i_result_writer (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .in_valid_i           (net_valid),
      .in_vd_i              (issue_vd),
      .in_data_i            (net_data),
      .permu_result_gnt_i   (permu_result_gnt_i),
      .in_ready_o           (writer_ready),
      .permu_result_req_o   (permu_result_req_o),
      .permu_result_addr_o  (permu_result_addr_o),
      .permu_result_wdata_o (permu_result_wdata_o),
      .commit_o             (commit)
   );

endmodule

`default_nettype wire

// File: hw/permu_result_writer.sv
// Result writer that holds the all-lane write request until every lane grants
`timescale 1ns/1ns
`default_nettype none

module permu_result_writer import permu_cfg_pkg::*; (
   input  wire logic                 clk_i,
   input  wire logic                 rst_ni,
   input  wire logic                 in_valid_i,
   input  wire vreg_t                in_vd_i,
   input  wire lane_data_t           in_data_i,
   input  wire logic [NumLanes-1:0]  permu_result_gnt_i,
   output logic                      in_ready_o,
   output logic [NumLanes-1:0]       permu_result_req_o,
   output vaddr_t [NumLanes-1:0]     permu_result_addr_o,
   output lane_data_t                permu_result_wdata_o,
   output logic                      commit_o
);

   logic       req_q;
   vaddr_t     addr_q;
   lane_data_t data_q;
   logic       load;
   logic       all_gnt;

   assign in_ready_o = !req_q;
   assign load       = in_valid_i && !req_q;
   // Only a grant on every lane in the same cycle counts
   assign all_gnt    = req_q && (&permu_result_gnt_i);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         req_q <= 1'b0;
      end else if (load) begin
         req_q <= 1'b1;
      end else if (all_gnt) begin
         req_q <= 1'b0;
      end
   end

   // Base word of vd in each lane
   always_ff @(posedge clk_i) begin
      if (load) begin
         addr_q <= vaddr_t'(in_vd_i * VregWordsPerLane);
         data_q <= in_data_i;
      end
   end

   assign permu_result_req_o   = {NumLanes{req_q}};
   assign permu_result_addr_o  = {NumLanes{addr_q}};
   assign permu_result_wdata_o = data_q;
   assign commit_o             = all_gnt;

endmodule

`default_nettype wire

// File: hw/permu_network.sv
// Operand collection, deshuffle, gather and reshuffle with a one-entry output stage
`timescale 1ns/1ns
`default_nettype none

module permu_network import permu_cfg_pkg::*; import permu_insn_pkg::*; (
   input  wire logic        clk_i,
   input  wire logic        rst_ni,
   input  wire logic        issue_valid_i,
   input  wire permu_mode_e issue_mode_i,
   input  wire logic        operand_valid_i,
   input  wire logic        sel_idx_val_i,
   input  wire lane_data_t  operand_i,
   input  wire logic        out_ready_i,
   output logic             operand_ready_o,
   output logic             out_valid_o,
   output lane_data_t       out_data_o
);

   // Element e sits in lane e mod 4, slot e div 4
   function automatic vec16_t deshuffle(input lane_data_t data);
      vec16_t lin;
      for (int e = 0; e < NumElems16; e++) begin
         lin[e] = data[e % NumLanes][Ew16Width*(e / NumLanes) +: Ew16Width];
      end
      return lin;
   endfunction

   function automatic lane_data_t reshuffle(input vec16_t lin);
      lane_data_t data;
      for (int e = 0; e < NumElems16; e++) begin
         data[e % NumLanes][Ew16Width*(e / NumLanes) +: Ew16Width] = lin[e];
      end
      return data;
   endfunction

   logic       val_present_q, idx_present_q;
   vec16_t     val_q, idx_q;
   logic       out_valid_q;
   lane_data_t out_data_q;
   logic       beat_fire, compute_fire;
   vec16_t     gather16;
   byte_vec_t  val_bytes, idx_bytes, gather8;
   lane_data_t result;

   ////////////////////////////////////////////////////////////
   // Operand collection
   ////////////////////////////////////////////////////////////

   assign operand_ready_o = issue_valid_i && !out_valid_q &&
                            !(val_present_q && idx_present_q);
   assign beat_fire       = operand_valid_i && operand_ready_o;
   assign compute_fire    = val_present_q && idx_present_q && !out_valid_q;

   always_ff @(posedge clk_i) begin
      if (beat_fire && sel_idx_val_i) idx_q <= deshuffle(operand_i);
      if (beat_fire && !sel_idx_val_i) val_q <= deshuffle(operand_i);
   end

   ////////////////////////////////////////////////////////////
   // Gather
   ////////////////////////////////////////////////////////////

   always_comb begin
      val_bytes = byte_vec_t'(val_q);
      idx_bytes = byte_vec_t'(idx_q);
      for (int k = 0; k < NumElems16; k++) begin
         gather16[k] = val_q[idx_q[k] % NumElems16];
      end
      for (int k = 0; k < NumBytes; k++) begin
         gather8[k] = val_bytes[idx_bytes[k] % NumBytes];
      end
      case (issue_mode_i)
         PERMU_GATHER8: result = reshuffle(vec16_t'(gather8));
         default:       result = reshuffle(gather16);
      endcase
   end

   // Output stage frees on hand-off
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         val_present_q <= 1'b0;
         idx_present_q <= 1'b0;
         out_valid_q   <= 1'b0;
      end else begin
         if (compute_fire) begin
            val_present_q <= 1'b0;
            idx_present_q <= 1'b0;
         end else if (beat_fire) begin
            if (sel_idx_val_i) idx_present_q <= 1'b1;
            else val_present_q <= 1'b1;
         end
         if (compute_fire) out_valid_q <= 1'b1;
         else if (out_ready_i) out_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (compute_fire) out_data_q <= result;
   end

   assign out_valid_o = out_valid_q;
   assign out_data_o  = out_data_q;

endmodule

`default_nettype wire

// File: hw/permu_insn_queue.sv
// Instruction queue with accept, issue and commit pointers and the done response
`timescale 1ns/1ns
`default_nettype none

module permu_insn_queue import permu_cfg_pkg::*; import permu_insn_pkg::*; (
   input  wire logic               clk_i,
   input  wire logic               rst_ni,
   input  wire logic               pe_req_valid_i,
   input  wire vid_t               pe_req_id_i,
   input  wire vreg_t              pe_req_vd_i,
   input  wire permu_mode_e        pe_req_mode_i,
   input  wire vfu_e               pe_req_vfu_i,
   input  wire logic               issue_done_i,
   input  wire logic               commit_i,
   output logic                    pe_req_ready_o,
   output logic                    issue_valid_o,
   output permu_mode_e             issue_mode_o,
   output vreg_t                   issue_vd_o,
   output logic [NrVInsn-1:0]      pe_resp_done_o
);

   // Entry storage
   vid_t        id_q   [InsnQueueDepth];
   vreg_t       vd_q   [InsnQueueDepth];
   permu_mode_e mode_q [InsnQueueDepth];

   logic [QPtrWidth-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
   logic [QCntWidth-1:0] issue_cnt_q, issue_cnt_d;
   logic [QCntWidth-1:0] commit_cnt_q, commit_cnt_d;
   logic                 ready_q;
   logic                 accept;
   logic [NrVInsn-1:0]   done_d, done_q;

   ////////////////////////////////////////////////////////////
   // Accept
   ////////////////////////////////////////////////////////////

   // Requests for other units fall through without a slot
   assign accept = pe_req_valid_i && ready_q && (pe_req_vfu_i == VFU_PERMU);

   always_ff @(posedge clk_i) begin
      if (accept) begin
         id_q[accept_pnt_q]   <= pe_req_id_i;
         vd_q[accept_pnt_q]   <= pe_req_vd_i;
         mode_q[accept_pnt_q] <= pe_req_mode_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Issue and commit bookkeeping
   ////////////////////////////////////////////////////////////

   always_comb begin
      issue_cnt_d  = issue_cnt_q;
      commit_cnt_d = commit_cnt_q;
      done_d       = '0;
      if (accept) begin
         issue_cnt_d  = issue_cnt_d + 1'b1;
         commit_cnt_d = commit_cnt_d + 1'b1;
      end
      if (issue_done_i) begin
         issue_cnt_d = issue_cnt_d - 1'b1;
      end
      if (commit_i) begin
         commit_cnt_d = commit_cnt_d - 1'b1;
         // Oldest entry finishes
         done_d[id_q[commit_pnt_q]] = 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         accept_pnt_q <= '0;
         issue_pnt_q  <= '0;
         commit_pnt_q <= '0;
         issue_cnt_q  <= '0;
         commit_cnt_q <= '0;
         ready_q      <= 1'b0;
         done_q       <= '0;
      end else begin
         if (accept) accept_pnt_q <= accept_pnt_q + 1'b1;
         if (issue_done_i) issue_pnt_q <= issue_pnt_q + 1'b1;
         if (commit_i) commit_pnt_q <= commit_pnt_q + 1'b1;
         issue_cnt_q  <= issue_cnt_d;
         commit_cnt_q <= commit_cnt_d;
         // Full until every committed slot is back
         ready_q      <= (commit_cnt_d != QCntWidth'(InsnQueueDepth));
         done_q       <= done_d;
      end
   end

   assign pe_req_ready_o = ready_q;
   assign issue_valid_o  = (issue_cnt_q != '0);
   assign issue_mode_o   = mode_q[issue_pnt_q];
   assign issue_vd_o     = vd_q[issue_pnt_q];
   assign pe_resp_done_o = done_q;

endmodule

`default_nettype wire

// File: hw/permu_insn_pkg.sv
// Instruction ids, queue depth, lookup modes and functional unit codes
`default_nettype none

package permu_insn_pkg;

   ////////////////////////////////////////////////////////////
   // Instruction ids and queue sizing
   ////////////////////////////////////////////////////////////

   localparam int IdWidth        = 3;
   localparam int NrVInsn        = 8;
   localparam int InsnQueueDepth = 4;

   // Pointer and counter widths of the instruction queue
   localparam int QPtrWidth = $clog2(InsnQueueDepth);
   localparam int QCntWidth = QPtrWidth + 1;

   typedef logic [IdWidth-1:0] vid_t;

   // Lookup mode of a permutation
   typedef enum logic [1:0] {
      PERMU_GATHER16 = 2'd0,
      PERMU_GATHER8  = 2'd1
   } permu_mode_e;

   // Target functional unit of a sequencer request
   typedef enum logic [1:0] {
      VFU_ALU   = 2'd0,
      VFU_PERMU = 2'd1,
      VFU_LOAD  = 2'd2
   } vfu_e;

endpackage

`default_nettype wire

// File: hw/permu_cfg_pkg.sv
// Lane, element and address widths, with the data types that carry them
`default_nettype none

package permu_cfg_pkg;

   ////////////////////////////////////////////////////////////
   // Lane geometry
   ////////////////////////////////////////////////////////////

   localparam int NumLanes         = 4;
   localparam int ElemWidth        = 64;
   localparam int Ew16PerLane      = 4;
   localparam int NumElems16       = 16;
   localparam int VregWordsPerLane = 8;

   // Derived widths for the gather views
   localparam int Ew16Width = ElemWidth / Ew16PerLane;
   localparam int NumBytes  = NumElems16 * 2;

   // One word per lane, four lanes per beat
   typedef logic [ElemWidth-1:0] elem_t;
   typedef elem_t [NumLanes-1:0] lane_data_t;

   // Deshuffled views of a beat, as 16-bit elements or as bytes
   typedef logic [NumElems16-1:0][Ew16Width-1:0] vec16_t;
   typedef logic [NumBytes-1:0][7:0] byte_vec_t;

   typedef logic [7:0] vaddr_t;
   typedef logic [4:0] vreg_t;

endpackage

`default_nettype wire
